// ==== all.f ====
+incdir+tests
verilog/renamePkg.sv
verilog/tagBuffer.sv
verilog/renameTable.sv
verilog/renameCsr.sv
verilog/renameUnit.sv
tests/renameUnitTb.sv

// ==== tests/renameTests.txt ====
# R ready repeat, then per lane: valid dstValid dst src0 src1 (decimal)
# C per lane: valid dst dstTag (decimal); M pulses mispredict for one cycle
# A write addr(hex) data(hex) slverr; data is the expected rdata, CSR_FREE uses the model
# Reset values
A 0 0 1 0
A 0 4 20 0
A 0 8 0 0
A 0 C 0 0
# First group, intra-group bypass, lane without destination
R 1 1 1 1 1 2 3 1 1 4 5 6
R 1 1 1 1 7 1 4 1 1 8 7 1
R 1 1 1 1 9 7 8 1 0 0 9 4
A 0 4 1B 0
A 0 8 6 0
# Commits, then two lanes committing one register
C 1 1 63 1 4 62
A 0 4 1D 0
R 1 1 1 1 7 7 1 0 0 0 0 0
C 1 7 61 1 7 58
A 0 4 1E 0
# Mispredict after uncommitted renames
R 1 1 1 1 1 1 8 1 1 2 2 1
M
A 0 4 20 0
A 0 C 1 0
R 1 1 1 1 10 1 2 1 1 11 8 9
# Back-pressure from the enable bit
A 1 0 0 0
A 0 0 0 0
R 0 1 1 1 12 10 11 1 1 13 12 0
A 1 0 1 0
R 1 1 1 1 12 10 11 1 1 13 12 0
# Use up every free tag, then free two by commit
R 1 14 1 1 14 14 15 1 1 15 14 15
A 0 4 0 0
R 0 1 1 1 16 0 0 0 0 0 0 0
C 1 10 61 1 11 60
R 1 1 1 1 16 0 0 1 1 17 16 10
A 0 8 2B 0
# APB errors and counter clear
A 1 4 0 1
A 1 6 0 1
A 0 2 0 1
A 1 0 3 0
A 0 8 0 0
A 0 0 1 0

// ==== tests/renameChecks.svh ====
`ifndef RENAME_CHECKS_SVH
`define RENAME_CHECKS_SVH

// With no result expected only the valid bit is meaningful
task automatic checkResult(input string name, input renameResult got,
                           input renameResult exp);
    logic bad;
    if (exp.valid)
        bad = (got !== exp);
    else
        bad = (got.valid !== 1'b0);
    if (bad) begin
        $display("CHECK FAILED at %0d ns: %s got %h expected %h", $time, name, got, exp);
        stopRun();
    end
endtask

// Read data is skipped for writes and error responses
task automatic checkRead(input string name, input apbRsp got, input apbRsp exp,
                         input logic withData);
    logic bad;
    bad = (got.ready !== exp.ready) || (got.slverr !== exp.slverr);
    if (withData && got.rdata !== exp.rdata)
        bad = 1'b1;
    if (bad) begin
        $display("CHECK FAILED at %0d ns: %s got %h expected %h", $time, name, got, exp);
        stopRun();
    end
endtask

task automatic checkReady(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("CHECK FAILED at %0d ns: %s got %b expected %b", $time, name, got, exp);
        stopRun();
    end
endtask

`endif

// ==== tests/renameUnitTb.sv ====
module renameUnitTb import renamePkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int LANES      = 2;
    localparam int WAIT_LIMIT = 200;     // Cycles before a wait gives up

    logic        clk;
    logic        rst;
    logic        mispredict;
    renameReq    renameIn [LANES];
    logic        renameReady;
    renameResult renameOut [LANES];
    commitReq    commitIn [LANES];
    apbReq       apbIn;
    apbRsp       apbOut;

    // Reference model state
    physTag      specModel [NUM_ARCH];
    physTag      comModel [NUM_ARCH];
    logic        usedModel [NUM_TAGS];
    logic        comFlags [NUM_TAGS];
    renameReq    laneReq [LANES];        // Group from the current stimulus line
    renameResult expOut [LANES];

    renameUnit #(.NUM_UOPS(LANES)) UUT (
        .clk(clk), .rst(rst), .mispredict(mispredict),
        .renameIn(renameIn), .renameReady(renameReady), .renameOut(renameOut),
        .commitIn(commitIn), .apbIn(apbIn), .apbOut(apbOut)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stopRun();
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    `include "renameChecks.svh"

    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic idleInputs();
        mispredict = 1'b0;
        apbIn      = '0;
        for (int i = 0; i < LANES; i++) begin
            renameIn[i] = '0;
            commitIn[i] = '0;
        end
    endtask

    task automatic resetModel();
        for (int r = 0; r < NUM_ARCH; r++) begin
            specModel[r] = physTag'(r);
            comModel[r]  = physTag'(r);
        end
        for (int t = 0; t < NUM_TAGS; t++) begin
            usedModel[t] = (t < NUM_ARCH);
            comFlags[t]  = (t < NUM_ARCH);
        end
    endtask

    function automatic int freeModel();
        int n;
        n = 0;
        for (int t = 0; t < NUM_TAGS; t++)
            if (!usedModel[t])
                n++;
        return n;
    endfunction

    // Lanes in order, so a later lane already sees an earlier lane's new mapping
    task automatic modelRename();
        for (int i = 0; i < LANES; i++) begin
            expOut[i] = '0;
            if (laneReq[i].valid) begin
                expOut[i].valid   = 1'b1;
                expOut[i].src0Tag = specModel[laneReq[i].src0];
                expOut[i].src1Tag = specModel[laneReq[i].src1];
                if (laneReq[i].dstValid) begin
                    for (int t = 0; t < NUM_TAGS; t++)
                        if (!usedModel[t])
                            expOut[i].dstTag = physTag'(t);   // Highest free tag wins
                    usedModel[expOut[i].dstTag] = 1'b1;
                    specModel[laneReq[i].dst]   = expOut[i].dstTag;
                end
            end
        end
    endtask

    task automatic modelCommit();
        logic   newest;
        physTag old;
        for (int i = 0; i < LANES; i++) begin
            if (commitIn[i].valid) begin
                newest = 1'b1;
                for (int j = i + 1; j < LANES; j++)
                    if (commitIn[j].valid && commitIn[j].dst == commitIn[i].dst)
                        newest = 1'b0;
                if (newest) begin
                    old = comModel[commitIn[i].dst];
                    usedModel[old] = 1'b0;
                    comFlags[old]  = 1'b0;
                    comModel[commitIn[i].dst]     = commitIn[i].dstTag;
                    usedModel[commitIn[i].dstTag] = 1'b1;
                    comFlags[commitIn[i].dstTag]  = 1'b1;
                end else begin
                    usedModel[commitIn[i].dstTag] = 1'b0;   // Overwritten in the group
                    comFlags[commitIn[i].dstTag]  = 1'b0;
                end
            end
        end
    endtask

    task automatic renameGroup(input logic expReady, input int count);
        int          cycles;
        renameResult none;
        none = '0;
        for (int n = 0; n < count; n++) begin
            for (int i = 0; i < LANES; i++)
                renameIn[i] = laneReq[i];
            if (expReady) begin
                cycles = 0;
                @(negedge clk);
                while (renameReady !== 1'b1) begin
                    cycles++;
                    if (cycles >= WAIT_LIMIT) begin
                        $display("Timeout at %0d ns: renameReady stayed low for %0d cycles",
                                 $time, WAIT_LIMIT);
                        stopRun();
                    end
                    @(negedge clk);
                end
                modelRename();
                nextCycle();
                idleInputs();
                @(negedge clk);
                for (int i = 0; i < LANES; i++)
                    checkResult($sformatf("renameOut[%0d]", i), renameOut[i], expOut[i]);
            end else begin
                // Decoder holds the group for a few cycles, then withdraws it
                for (int c = 0; c < 4; c++) begin
                    @(negedge clk);
                    checkReady("renameReady", renameReady, 1'b0);
                    for (int i = 0; i < LANES; i++)
                        checkResult($sformatf("renameOut[%0d]", i), renameOut[i], none);
                end
            end
            nextCycle();
            idleInputs();
        end
    endtask

    task automatic flushPipe();
        mispredict = 1'b1;
        for (int r = 0; r < NUM_ARCH; r++)
            specModel[r] = comModel[r];
        for (int t = 0; t < NUM_TAGS; t++)
            usedModel[t] = usedModel[t] & comFlags[t];
        nextCycle();
        idleInputs();
    endtask

    task automatic apbAccess(input logic wr, input logic [3:0] addr,
                             input logic [31:0] data, input logic expErr);
        apbRsp expRsp;
        int    cycles;
        apbIn.sel    = 1'b1;         // Setup phase
        apbIn.enable = 1'b0;
        apbIn.write  = wr;
        apbIn.addr   = addr;
        apbIn.wdata  = wr ? data : 32'h0;
        nextCycle();
        apbIn.enable = 1'b1;
        cycles = 0;
        @(negedge clk);
        while (apbOut.ready !== 1'b1) begin
            cycles++;
            if (cycles >= WAIT_LIMIT) begin
                $display("Timeout at %0d ns: APB ready never rose for address %h", $time, addr);
                stopRun();
            end
            @(negedge clk);
        end
        expRsp.ready  = 1'b1;
        expRsp.slverr = expErr;
        expRsp.rdata  = (addr == CSR_FREE) ? 32'(freeModel()) : data;  // Free count from model
        checkRead("apbOut", apbOut, expRsp, !wr && !expErr);
        nextCycle();
        idleInputs();
    endtask

    task automatic rejectLine(input string line);
        $display("Malformed line in the stimulus file: %s", line);
        stopRun();
    endtask

    initial begin
        int    fd;
        string line;
        string rest;
        byte   kind;
        int    f [12];
        rst = 1'b1;
        idleInputs();
        resetModel();
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        fd = $fopen("tests/renameTests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file tests/renameTests.txt");
            stopRun();
        end
        while ($fgets(line, fd) > 0) begin
            kind = line.getc(0);
            rest = line.substr(1, line.len() - 1);
            case (kind)
                "R": begin
                    if ($sscanf(rest, "%d %d %d %d %d %d %d %d %d %d %d %d",
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                                f[8], f[9], f[10], f[11]) != 12)
                        rejectLine(line);
                    for (int i = 0; i < LANES; i++) begin
                        laneReq[i].valid    = 1'(f[2 + 5 * i]);
                        laneReq[i].dstValid = 1'(f[3 + 5 * i]);
                        laneReq[i].dst      = archReg'(f[4 + 5 * i]);
                        laneReq[i].src0     = archReg'(f[5 + 5 * i]);
                        laneReq[i].src1     = archReg'(f[6 + 5 * i]);
                    end
                    renameGroup(1'(f[0]), f[1]);
                end
                "C": begin
                    if ($sscanf(rest, "%d %d %d %d %d %d",
                                f[0], f[1], f[2], f[3], f[4], f[5]) != 6)
                        rejectLine(line);
                    for (int i = 0; i < LANES; i++) begin
                        commitIn[i].valid  = 1'(f[3 * i]);
                        commitIn[i].dst    = archReg'(f[3 * i + 1]);
                        commitIn[i].dstTag = physTag'(f[3 * i + 2]);
                    end
                    modelCommit();
                    nextCycle();
                    idleInputs();
                end
                "M": flushPipe();
                "A": begin
                    if ($sscanf(rest, "%d %h %h %d", f[0], f[1], f[2], f[3]) != 4)
                        rejectLine(line);
                    apbAccess(1'(f[0]), 4'(f[1]), 32'(f[2]), 1'(f[3]));
                end
                "#", " ", "\n", "\r": ;     // Comments and blank lines
                default: rejectLine(line);
            endcase
        end
        $fclose(fd);

        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== verilog/renameCsr.sv ====
module renameCsr import renamePkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  apbReq      apbIn,
    input  logic [6:0] freeCount,
    input  logic [1:0] acceptCount,
    input  logic       mispredict,
    output apbRsp      apbOut,
    output logic       renameEnable
);

    logic        ctrlEnable;
    logic [31:0] renamedCnt;
    logic [31:0] flushCnt;
    logic        access;
    logic        legal;
    logic        wrEn;
    logic        clearCnt;
    logic [31:0] rdVal;

    assign access = apbIn.sel & apbIn.enable;   // Access phase

    // Address decode and read mux
    always_comb begin
        rdVal = '0;
        legal = 1'b1;
        case (apbIn.addr)
            CSR_CTRL: begin
                rdVal = {31'b0, ctrlEnable};   // Clear bit reads back as 0
            end
            CSR_FREE: begin
                rdVal = {25'b0, freeCount};
                legal = ~apbIn.write;
            end
            CSR_RENAMED: begin
                rdVal = renamedCnt;
                legal = ~apbIn.write;
            end
            CSR_FLUSHES: begin
                rdVal = flushCnt;
                legal = ~apbIn.write;
            end
            default: begin
                legal = 1'b0;                  // Unmapped
            end
        endcase
    end

    assign wrEn     = access & apbIn.write & legal;
    assign clearCnt = wrEn && apbIn.addr == CSR_CTRL && apbIn.wdata[1];

    always_comb begin
        apbOut.rdata  = (access && !apbIn.write) ? rdVal : '0;
        apbOut.ready  = 1'b1;                 // No wait states
        apbOut.slverr = access & ~legal;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrlEnable <= 1'b1;
            renamedCnt <= '0;
            flushCnt   <= '0;
        end else begin
            if (wrEn && apbIn.addr == CSR_CTRL)
                ctrlEnable <= apbIn.wdata[0];
            if (clearCnt) begin
                renamedCnt <= '0;
                flushCnt   <= '0;
            end else begin
                renamedCnt <= renamedCnt + {30'b0, acceptCount};  // Wraps
                flushCnt   <= flushCnt + {31'b0, mispredict};
            end
        end
    end

    assign renameEnable = ctrlEnable;

endmodule

// ==== verilog/renamePkg.sv ====
package renamePkg;

    localparam int NUM_TAGS = 64;           // Physical register file size
    localparam int NUM_ARCH = 32;           // Architectural registers

    typedef logic [5:0] physTag;
    typedef logic [4:0] archReg;
    typedef logic [6:0] prevTag;            // Bit 6 set when no previous mapping

    // One lane of a rename group from decode
    typedef struct packed {
        logic   valid;
        logic   dstValid;
        archReg dst;
        archReg src0;
        archReg src1;
    } renameReq;

    typedef struct packed {
        logic   valid;
        physTag dstTag;
        physTag src0Tag;
        physTag src1Tag;
    } renameResult;

    // One lane of a commit group from the ROB
    typedef struct packed {
        logic   valid;
        archReg dst;
        physTag dstTag;
    } commitReq;

    typedef struct packed {
        logic        sel;
        logic        enable;
        logic        write;
        logic [3:0]  addr;
        logic [31:0] wdata;
    } apbReq;

    typedef struct packed {
        logic [31:0] rdata;
        logic        ready;
        logic        slverr;
    } apbRsp;

    // Register map of the control block
    localparam logic [3:0] CSR_CTRL    = 4'h0;
    localparam logic [3:0] CSR_FREE    = 4'h4;
    localparam logic [3:0] CSR_RENAMED = 4'h8;
    localparam logic [3:0] CSR_FLUSHES = 4'hC;

endpackage

// ==== verilog/renameTable.sv ====
module renameTable import renamePkg::*; #(
    parameter int NUM_UOPS = 2
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                mispredict,
    input  logic                accept,
    input  renameReq            renameIn [NUM_UOPS],
    input  physTag              allocTag [NUM_UOPS],
    input  commitReq            commitIn [NUM_UOPS],
    output physTag [1:0]        srcTags [NUM_UOPS],
    output logic [NUM_UOPS-1:0] allocReq,
    output logic [NUM_UOPS-1:0] commitNewest,
    output prevTag              commitPrevTag [NUM_UOPS]
);

    physTag specMap [NUM_ARCH];    // Speculative map, read at rename
    physTag comMap [NUM_ARCH];     // Committed map
    physTag comMapNext [NUM_ARCH];

    always_comb begin
        for (int i = 0; i < NUM_UOPS; i++)
            allocReq[i] = renameIn[i].valid & renameIn[i].dstValid;
    end

    // Source lookup with bypass from earlier lanes of the same group
    always_comb begin
        for (int i = 0; i < NUM_UOPS; i++) begin
            srcTags[i][0] = specMap[renameIn[i].src0];
            srcTags[i][1] = specMap[renameIn[i].src1];
            for (int j = 0; j < i; j++) begin
                // Later writer wins, so scan upward
                if (allocReq[j] && renameIn[j].dst == renameIn[i].src0)
                    srcTags[i][0] = allocTag[j];
                if (allocReq[j] && renameIn[j].dst == renameIn[i].src1)
                    srcTags[i][1] = allocTag[j];
            end
        end
    end

    // A commit lane is newest when no later lane commits the same register
    always_comb begin
        for (int i = 0; i < NUM_UOPS; i++) begin
            commitNewest[i] = commitIn[i].valid;
            for (int j = i + 1; j < NUM_UOPS; j++) begin
                if (commitIn[j].valid && commitIn[j].dst == commitIn[i].dst)
                    commitNewest[i] = 1'b0;
            end
            commitPrevTag[i] = {~commitNewest[i], comMap[commitIn[i].dst]};
        end
    end

    always_comb begin
        comMapNext = comMap;
        for (int i = 0; i < NUM_UOPS; i++) begin
            if (commitNewest[i])
                comMapNext[commitIn[i].dst] = commitIn[i].dstTag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < NUM_ARCH; r++) begin
                specMap[r] <= physTag'(r);  // Identity mapping out of reset
                comMap[r]  <= physTag'(r);
            end
        end else begin
            comMap <= comMapNext;
            if (mispredict) begin
                specMap <= comMapNext;      // Includes this cycle's commits
            end else if (accept) begin
                for (int i = 0; i < NUM_UOPS; i++) begin
                    if (allocReq[i])
                        specMap[renameIn[i].dst] <= allocTag[i];
                end
            end
        end
    end

endmodule

// ==== verilog/renameUnit.sv ====
module renameUnit import renamePkg::*; #(
    parameter int NUM_UOPS = 2
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        mispredict,
    input  renameReq    renameIn [NUM_UOPS],
    output logic        renameReady,
    output renameResult renameOut [NUM_UOPS],
    input  commitReq    commitIn [NUM_UOPS],
    input  apbReq       apbIn,
    output apbRsp       apbOut
);

    logic [NUM_UOPS-1:0] allocReq;
    logic [NUM_UOPS-1:0] bufReq;
    logic [NUM_UOPS-1:0] commitNewest;
    prevTag              commitPrevTag [NUM_UOPS];
    physTag              allocTag [NUM_UOPS];
    physTag [1:0]        srcTags [NUM_UOPS];
    logic                allocOk;
    logic                accept;
    logic                renameEnable;
    logic [6:0]          freeCount;
    logic [1:0]          acceptCount;
    logic [NUM_UOPS-1:0] outValid;
    physTag              outDst [NUM_UOPS];
    physTag [1:0]        outSrc [NUM_UOPS];

    // Requests only reach the free list while renaming is enabled
    assign bufReq = allocReq & {NUM_UOPS{renameEnable}};

    assign accept      = allocOk & renameEnable & ~mispredict;
    assign renameReady = accept;

    always_comb begin
        acceptCount = '0;
        for (int i = 0; i < NUM_UOPS; i++) begin
            if (accept && renameIn[i].valid)
                acceptCount = acceptCount + 2'd1;
        end
    end

    tagBuffer #(.NUM_UOPS(NUM_UOPS)) tagBuf (
        .clk(clk), .rst(rst), .mispredict(mispredict),
        .allocReq(bufReq), .commitIn(commitIn),
        .commitNewest(commitNewest), .commitPrevTag(commitPrevTag),
        .allocTag(allocTag), .allocOk(allocOk), .freeCount(freeCount)
    );

    renameTable #(.NUM_UOPS(NUM_UOPS)) mapTable (
        .clk(clk), .rst(rst), .mispredict(mispredict), .accept(accept),
        .renameIn(renameIn), .allocTag(allocTag), .commitIn(commitIn),
        .srcTags(srcTags), .allocReq(allocReq),
        .commitNewest(commitNewest), .commitPrevTag(commitPrevTag)
    );

    renameCsr csr (
        .clk(clk), .rst(rst), .apbIn(apbIn), .freeCount(freeCount),
        .acceptCount(acceptCount), .mispredict(mispredict),
        .apbOut(apbOut), .renameEnable(renameEnable)
    );

    always_ff @(posedge clk) begin
        if (rst)
            outValid <= '0;
        else
            for (int i = 0; i < NUM_UOPS; i++)
                outValid[i] <= accept & renameIn[i].valid;
    end

    // Result payload, captured on acceptance
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_UOPS; i++) begin
            if (accept) begin
                outDst[i] <= renameIn[i].dstValid ? allocTag[i] : '0;
                outSrc[i] <= srcTags[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_UOPS; i++) begin
            renameOut[i].valid   = outValid[i];
            renameOut[i].dstTag  = outDst[i];
            renameOut[i].src0Tag = outSrc[i][0];
            renameOut[i].src1Tag = outSrc[i][1];
        end
    end

endmodule

// ==== verilog/tagBuffer.sv ====
module tagBuffer import renamePkg::*; #(
    parameter int NUM_UOPS = 2
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                mispredict,
    input  logic [NUM_UOPS-1:0] allocReq,
    input  commitReq            commitIn [NUM_UOPS],
    input  logic [NUM_UOPS-1:0] commitNewest,
    input  prevTag              commitPrevTag [NUM_UOPS],
    output physTag              allocTag [NUM_UOPS],
    output logic                allocOk,
    output logic [6:0]          freeCount
);

    logic [NUM_TAGS-1:0] used;
    logic [NUM_TAGS-1:0] committed;
    logic [NUM_TAGS-1:0] usedNext;
    logic [NUM_TAGS-1:0] committedNext;
    logic [6:0]          freeNext;

    // Lanes needing a tag take free tags from the top down, in lane order
    always_comb begin
        logic [NUM_TAGS-1:0] avail;
        logic                found;
        avail   = ~used;
        allocOk = 1'b1;
        for (int i = 0; i < NUM_UOPS; i++) begin
            allocTag[i] = '0;
            found       = 1'b0;
            if (allocReq[i]) begin
                for (int t = NUM_TAGS - 1; t >= 0; t--) begin
                    if (avail[t] && !found) begin
                        allocTag[i] = physTag'(t);
                        found       = 1'b1;
                    end
                end
                if (found)
                    avail[allocTag[i]] = 1'b0;  // Not offered to a later lane
                allocOk = allocOk & found;
            end
        end
    end

    // Next flag state: allocation, then commit, then flush recovery
    always_comb begin
        usedNext      = used;
        committedNext = committed;

        // Allocation only happens for an accepted group
        if (allocOk && !mispredict) begin
            for (int i = 0; i < NUM_UOPS; i++) begin
                if (allocReq[i])
                    usedNext[allocTag[i]] = 1'b1;
            end
        end

        for (int i = 0; i < NUM_UOPS; i++) begin
            if (commitIn[i].valid) begin
                if (commitNewest[i]) begin
                    if (!commitPrevTag[i][6]) begin
                        usedNext[commitPrevTag[i][5:0]]      = 1'b0;  // Old mapping retired
                        committedNext[commitPrevTag[i][5:0]] = 1'b0;
                    end
                    usedNext[commitIn[i].dstTag]      = 1'b1;
                    committedNext[commitIn[i].dstTag] = 1'b1;
                end else begin
                    // Overwritten within the same commit group
                    usedNext[commitIn[i].dstTag]      = 1'b0;
                    committedNext[commitIn[i].dstTag] = 1'b0;
                end
            end
        end

        if (mispredict)
            usedNext = usedNext & committedNext;  // Drop all speculative tags
    end

    always_comb begin
        freeNext = '0;
        for (int t = 0; t < NUM_TAGS; t++)
            freeNext = freeNext + {6'b0, ~usedNext[t]};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            used      <= {{(NUM_TAGS - NUM_ARCH){1'b0}}, {NUM_ARCH{1'b1}}};
            committed <= {{(NUM_TAGS - NUM_ARCH){1'b0}}, {NUM_ARCH{1'b1}}};
            freeCount <= 7'(NUM_TAGS - NUM_ARCH);
        end else begin
            used      <= usedNext;
            committed <= committedNext;
            freeCount <= freeNext;
        end
    end

endmodule
